// ==== src.f ====
+incdir+tests
src/aesPkg.sv
src/colPkg.sv
src/tboxLanePair.sv
src/addRoundKeyStage.sv
src/aesColumnRound.sv
tests/tbAesColumn.sv

// ==== Bender.yml ====
package:
  name: aes_column_round

sources:
  - src/aesPkg.sv
  - src/colPkg.sv
  - src/tboxLanePair.sv
  - src/addRoundKeyStage.sv
  - src/aesColumnRound.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tbAesColumn.sv

// ==== tests/aesColumnRef.svh ====
`ifndef AES_COLUMN_REF_SVH
`define AES_COLUMN_REF_SVH

// multiply by x in GF(2^8), polynomial x^8 + x^4 + x^3 + x + 1
function automatic aesPkg::byte_t xtime(input aesPkg::byte_t v);
   aesPkg::byte_t shifted;
   shifted = aesPkg::byte_t'(v << 1);
   if (v[7]) begin
      shifted = shifted ^ 8'h1B;
   end
   return shifted;
endfunction

// expected outWord, row r of the column is byte 3-r of the word
function automatic aesPkg::word_t expectedColumn(
   input colPkg::colOp_t op,
   input aesPkg::word_t  word,
   input aesPkg::word_t  key
);
   aesPkg::byte_t a [4];   // substituted column
   aesPkg::byte_t m [4];   // mixed column
   aesPkg::word_t result;
   for (int r = 0; r < 4; r++) begin
      a[r] = aesPkg::sBox[word[8*(3-r) +: 8]];
   end
   case (op)
      colPkg::opMix: begin
         // standard MixColumns row, coefficients 2 3 1 1
         for (int r = 0; r < 4; r++) begin
            m[r] = xtime(a[r]) ^ xtime(a[(r+1)%4]) ^ a[(r+1)%4] ^ a[(r+2)%4] ^ a[(r+3)%4];
         end
         result = {m[0], m[1], m[2], m[3]};
      end
      colPkg::opFinal: result = {a[0], a[1], a[2], a[3]};
      default:         result = word;   // plaintext passes straight to the key add
   endcase
   return result ^ key;
endfunction

`endif

// ==== tests/tbAesColumn.sv ====
`timescale 1ns/1ps

module tbAesColumn;

   localparam int loadItems   = 100;
   localparam int mixItems    = 201;   // zero vector plus random items
   localparam int finalItems  = 401;   // zero vector, finals and at most one other op each
   localparam int stallItems  = 300;
   localparam int streamItems = 64;
   localparam int totalItems  = loadItems + mixItems + finalItems + stallItems + streamItems;
   localparam int cycleLimit  = 4 * totalItems + 200;
   localparam int expLatency  = 3;

   logic           CLK;
   logic           arstN;
   logic           inValid;
   logic           inReady;
   colPkg::colOp_t inOp;
   aesPkg::word_t  inWord;
   aesPkg::word_t  inKey;
   logic           outReady;
   logic           outValid;
   aesPkg::word_t  outWord;

   aesPkg::word_t  expQueue [$];      // reference results in acceptance order
   int             acceptQueue [$];   // negedge index of each acceptance
   int             errorCount = 0;
   int             checkCount = 0;
   int             testStartErrors = 0;
   int             cycleCount = 0;
   int             negCount = 0;
   int             lastOutNeg = -1;
   int             acceptNeg;
   logic           checkTiming = 1'b0;
   logic           readyRandom = 1'b0;
   logic           stallSeen = 1'b0;
   aesPkg::word_t  stallWord;
   aesPkg::word_t  lastOutWord;

   `include "aesColumnRef.svh"

   aesColumnRound dut0 (
      .CLK      (CLK),
      .arstN    (arstN),
      .inValid  (inValid),
      .inOp     (inOp),
      .inWord   (inWord),
      .inKey    (inKey),
      .outReady (outReady),
      .inReady  (inReady),
      .outValid (outValid),
      .outWord  (outWord)
   );

   initial begin
      CLK = 1'b0;
      forever #5 CLK = ~CLK;
   end

   initial begin
      while (cycleCount < cycleLimit) begin
         @(posedge CLK);
         cycleCount++;
      end
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Something failed");
      $finish;
   end

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
      end
   endtask

   function automatic colPkg::colOp_t randomOp();
      colPkg::colOp_t op;
      case ($urandom_range(0, 2))
         0:       op = colPkg::opLoad;
         1:       op = colPkg::opMix;
         default: op = colPkg::opFinal;
      endcase
      return op;
   endfunction

   // called at posedge + 1 ns, returns at posedge + 1 ns after the transfer
   task automatic sendItem(input colPkg::colOp_t op, input aesPkg::word_t word,
                           input aesPkg::word_t key);
      inOp    = op;
      inWord  = word;
      inKey   = key;
      inValid = 1'b1;
      @(negedge CLK);
      while (!inReady) begin
         @(negedge CLK);
      end
      @(posedge CLK);
      #1;
      inValid = 1'b0;
   endtask

   task automatic idleCycles(input int n);
      repeat (n) begin
         @(posedge CLK);
         #1;
      end
   endtask

   task automatic drainPipeline();
      do begin
         @(posedge CLK);
      end while (expQueue.size() != 0);
      #1;
   endtask

   task automatic reportTest(input string name);
      $display("test %s: done, %0d errors", name, errorCount - testStartErrors);
      testStartErrors = errorCount;
   endtask

   always @(posedge CLK) begin
      #1;
      if (readyRandom) begin
         outReady = ($urandom_range(0, 1) == 1);   // 50% back-pressure
      end else begin
         outReady = 1'b1;
      end
   end

   // compare process samples halfway between edges
   always @(negedge CLK) begin
      negCount++;
      if (arstN) begin
         checkValue("inReady", !(outValid && !outReady), inReady);
         if (stallSeen) begin
            checkValue("outValid", 1, outValid);
            checkValue("outWord", stallWord, outWord);
         end
         stallSeen = outValid && !outReady;
         stallWord = outWord;
         if (inValid && inReady) begin
            expQueue.push_back(expectedColumn(inOp, inWord, inKey));
            acceptQueue.push_back(negCount);
         end
         if (outValid && outReady) begin
            if (expQueue.size() == 0) begin
               errorCount++;
               $display("an output transfer arrived with no item outstanding");
            end else begin
               checkValue("outWord", expQueue.pop_front(), outWord);
               acceptNeg = acceptQueue.pop_front();
               if (checkTiming) begin
                  checkValue("latency", expLatency, negCount - acceptNeg);
                  if (lastOutNeg >= 0) begin
                     checkValue("output gap", 1, negCount - lastOutNeg);   // one per cycle
                  end
               end
               lastOutNeg  = negCount;
               lastOutWord = outWord;
            end
         end
      end
   end

   initial begin
      void'($urandom(32'h2096_1bee));
      arstN     = 1'b0;
      inValid   = 1'b0;
      inOp      = colPkg::opLoad;
      inWord    = '0;
      inKey     = '0;
      outReady  = 1'b1;

      repeat (16) begin
         @(negedge CLK);
         checkValue("outValid", 0, outValid);
         checkValue("inReady", 1, inReady);
      end
      @(posedge CLK);
      #1;
      arstN = 1'b1;
      repeat (2) begin
         @(negedge CLK);
         checkValue("outValid", 0, outValid);
         checkValue("inReady", 1, inReady);
      end
      @(posedge CLK);
      #1;
      reportTest("reset");

      repeat (loadItems) sendItem(colPkg::opLoad, $urandom, $urandom);
      drainPipeline();
      reportTest("load");

      sendItem(colPkg::opMix, '0, '0);
      drainPipeline();
      checkValue("outWord", 32'h63636363, lastOutWord);
      repeat (mixItems - 1) sendItem(colPkg::opMix, $urandom, $urandom);
      drainPipeline();
      reportTest("mix");

      sendItem(colPkg::opFinal, '0, '0);
      drainPipeline();
      checkValue("outWord", 32'h63636363, lastOutWord);
      repeat (200) begin
         sendItem(colPkg::opFinal, $urandom, $urandom);
         if ($urandom_range(0, 1) == 1) begin
            if ($urandom_range(0, 1) == 1) begin
               sendItem(colPkg::opMix, $urandom, $urandom);
            end else begin
               sendItem(colPkg::opLoad, $urandom, $urandom);
            end
         end
      end
      drainPipeline();
      reportTest("final");

      readyRandom = 1'b1;
      repeat (stallItems) begin
         sendItem(randomOp(), $urandom, $urandom);
         idleCycles($urandom_range(0, 1));   // bubbles between items
      end
      drainPipeline();
      readyRandom = 1'b0;
      reportTest("back-pressure");

      idleCycles(2);
      lastOutNeg  = -1;
      checkTiming = 1'b1;
      repeat (streamItems) sendItem(randomOp(), $urandom, $urandom);
      drainPipeline();
      checkTiming = 1'b0;
      reportTest("throughput");

      $display("summary: %0d checks, %0d errors", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== src/aesColumnRound.sv ====
`timescale 1ns/1ps

module aesColumnRound (
   input  logic           CLK,
   input  logic           arstN,
   input  logic           inValid,
   input  colPkg::colOp_t inOp,
   input  aesPkg::word_t  inWord,
   input  aesPkg::word_t  inKey,
   input  logic           outReady,
   output logic           inReady,
   output logic           outValid,
   output aesPkg::word_t  outWord
);

   aesPkg::word_t hiLaneWord;   // bytes 3 and 2
   aesPkg::word_t loLaneWord;   // bytes 1 and 0
   logic          advance;

   tboxLanePair #(
      .pairBase (2)
   ) hiPair0 (
      .CLK      (CLK),
      .arstN    (arstN),
      .advance  (advance),
      .inOp     (inOp),
      .hiByte   (inWord[3*aesPkg::byteWidth +: aesPkg::byteWidth]),
      .loByte   (inWord[2*aesPkg::byteWidth +: aesPkg::byteWidth]),
      .laneWord (hiLaneWord)
   );

   tboxLanePair #(
      .pairBase (0)
   ) loPair0 (
      .CLK      (CLK),
      .arstN    (arstN),
      .advance  (advance),
      .inOp     (inOp),
      .hiByte   (inWord[1*aesPkg::byteWidth +: aesPkg::byteWidth]),
      .loByte   (inWord[0 +: aesPkg::byteWidth]),
      .laneWord (loLaneWord)
   );

   addRoundKeyStage ark0 (
      .CLK      (CLK),
      .arstN    (arstN),
      .inValid  (inValid),
      .inKey    (inKey),
      .hiWord   (hiLaneWord),
      .loWord   (loLaneWord),
      .outReady (outReady),
      .inReady  (inReady),
      .advance  (advance),
      .outValid (outValid),
      .outWord  (outWord)
   );

endmodule

// ==== src/addRoundKeyStage.sv ====
`timescale 1ns/1ps

module addRoundKeyStage (
   input  logic          CLK,
   input  logic          arstN,
   input  logic          inValid,
   input  aesPkg::word_t inKey,
   input  aesPkg::word_t hiWord,
   input  aesPkg::word_t loWord,
   input  logic          outReady,
   output logic          inReady,
   output logic          advance,
   output logic          outValid,
   output aesPkg::word_t outWord
);

   logic [colPkg::pipeLatency-1:0] validPipe;   // bit 0 is stage 1
   aesPkg::word_t                  keyD1;
   aesPkg::word_t                  keyD2;       // lines up with the lane words

   // whole pipeline moves as one, stalls only on a held result
   assign advance  = !outValid || outReady;
   assign inReady  = advance;
   assign outValid = validPipe[colPkg::pipeLatency-1];

   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         validPipe <= '0;
      end else if (advance) begin
         validPipe <= {validPipe[colPkg::pipeLatency-2:0], inValid};   // bubbles shift as 0
      end
   end

   always_ff @(posedge CLK) begin
      if (advance) begin
         keyD1   <= inKey;
         keyD2   <= keyD1;
         outWord <= hiWord ^ loWord ^ keyD2;   // stage 3 result
      end
   end

   // a stalled result must not change under the consumer
   holdWhileStalled: assert property (
      @(posedge CLK) disable iff (!arstN)
      outValid && !outReady |=> outValid && $stable(outWord)
   ) else $error("addRoundKeyStage: output changed while stalled");

   noXOnOutput: assert property (
      @(posedge CLK) disable iff (!arstN)
      outValid |-> !$isunknown(outWord)
   ) else $error("addRoundKeyStage: unknown bits on outWord while valid");

endmodule

// ==== src/tboxLanePair.sv ====
`timescale 1ns/1ps

module tboxLanePair #(
   parameter int pairBase = 0   // byte position of the lower lane
) (
   input  logic           CLK,
   input  logic           arstN,
   input  logic           advance,
   input  colPkg::colOp_t inOp,
   input  aesPkg::byte_t  hiByte,
   input  aesPkg::byte_t  loByte,
   output aesPkg::word_t  laneWord
);

   localparam int topByte = aesPkg::wordWidth / aesPkg::byteWidth - 1;

   aesPkg::byte_t  laneIn [colPkg::lanesPerPair];   // lane 0 is the lower byte position
   aesPkg::byte_t  sReg   [colPkg::lanesPerPair];   // stage 1 S-box outputs
   aesPkg::byte_t  rawReg [colPkg::lanesPerPair];   // stage 1 raw bytes for Load
   colPkg::colOp_t opReg;
   aesPkg::word_t  pairWord;                        // both contributions XORed

   assign laneIn[0] = loByte;
   assign laneIn[1] = hiByte;

   // multiply by x in GF(2^8)
   function automatic aesPkg::byte_t gfDouble(input aesPkg::byte_t b);
      aesPkg::byte_t shifted;
      shifted = {b[aesPkg::byteWidth-2:0], 1'b0};
      if (b[aesPkg::byteWidth-1]) begin
         shifted = shifted ^ aesPkg::reducePoly;
      end
      return shifted;
   endfunction

   // one byte's share of the output column at byte position pos
   function automatic aesPkg::word_t placeContrib(
      input colPkg::colOp_t op,
      input aesPkg::byte_t  s,
      input aesPkg::byte_t  raw,
      input int             pos
   );
      aesPkg::byte_t                  d;
      aesPkg::word_t                  base;
      logic [2*aesPkg::wordWidth-1:0] twice;
      aesPkg::word_t                  result;
      d     = gfDouble(s);
      base  = {d, s, s, d ^ s};                                   // T0 entry
      twice = {base, base} >> (aesPkg::byteWidth * (topByte - pos));  // rotate right
      case (op)
         colPkg::opMix:   result = twice[aesPkg::wordWidth-1:0];
         colPkg::opFinal: result = aesPkg::word_t'(s) << (aesPkg::byteWidth * pos);
         colPkg::opLoad:  result = aesPkg::word_t'(raw) << (aesPkg::byteWidth * pos);
         default:         result = '0;
      endcase
      return result;
   endfunction

   // stage 1 opcode
   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         opReg <= colPkg::opLoad;
      end else if (advance) begin
         opReg <= inOp;
      end
   end

   // stage 1 lookups
   always_ff @(posedge CLK) begin
      if (advance) begin
         for (int i = 0; i < colPkg::lanesPerPair; i++) begin
            sReg[i]   <= aesPkg::sBox[laneIn[i]];
            rawReg[i] <= laneIn[i];
         end
      end
   end

   always_comb begin
      pairWord = '0;
      for (int i = 0; i < colPkg::lanesPerPair; i++) begin
         pairWord = pairWord ^ placeContrib(opReg, sReg[i], rawReg[i], pairBase + i);
      end
   end

   // stage 2 placed contribution
   always_ff @(posedge CLK) begin
      if (advance) begin
         laneWord <= pairWord;
      end
   end

   // a stray opcode would silently zero this pair's contribution
   opLegal: assert property (
      @(posedge CLK) disable iff (!arstN)
      advance |-> opReg inside {colPkg::opLoad, colPkg::opMix, colPkg::opFinal}
   ) else $error("tboxLanePair: illegal opcode %0d in stage 1", opReg);

endmodule

// ==== src/colPkg.sv ====
package colPkg;

   // what each byte lane does with its input byte
   typedef enum logic [1:0] {
      opLoad  = 2'd0,   // initial AddRoundKey on the plaintext word
      opMix   = 2'd1,   // full round through S-box and MixColumns
      opFinal = 2'd2    // last round, S-box only
   } colOp_t;

   // edges from acceptance to a valid result
   localparam int pipeLatency = 3;

   // byte lanes handled by one lane pair
   localparam int lanesPerPair = 2;

endpackage

// ==== src/aesPkg.sv ====
package aesPkg;

   localparam int byteWidth = 8;
   localparam int wordWidth = 32;

   typedef logic [byteWidth-1:0] byte_t;
   typedef logic [wordWidth-1:0] word_t;   // byte 3 sits in the top bits

   // GF(2^8) doubling folds the carry back in with x^4 + x^3 + x + 1
   localparam byte_t reducePoly = 8'h1B;

   // forward S-box, indexed by the input byte
   localparam byte_t sBox [256] = '{
      8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
      8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
      8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
      8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
      8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
      8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
      8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
      8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
      8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
      8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
      8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
      8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
      8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
      8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
      8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
      8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
      8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
      8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
      8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
      8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
      8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
      8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
      8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
      8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
      8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
      8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
      8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
      8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
      8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
      8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
      8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
      8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
   };

endpackage
